// ==== hw/dispatch_pkg.sv ====
package dispatch_pkg;

    // datapath and pc width
    localparam int xlen = 32;
    // architectural register index
    localparam int reg_w = 5;
    // one pending bit per register
    localparam int num_arch_regs = 32;

    // rv32 major opcodes
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jal   = 7'b1101111;
    localparam logic [6:0] op_jalr  = 7'b1100111;
    localparam logic [6:0] op_br    = 7'b1100011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_reg   = 7'b0110011;

    // M extension marker in funct7 of a register op
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    // one instruction word, two decodings
    typedef union packed {
        // register form, routing and operand fields
        struct packed {
            logic [6:0]       funct7;
            logic [reg_w-1:0] rs2;
            logic [reg_w-1:0] rs1;
            logic [2:0]       funct3;
            logic [reg_w-1:0] rd;
            logic [6:0]       opcode;
        } r;
        // jal form, immediate bits scrambled as in the ISA
        struct packed {
            logic             imm_20;
            logic [9:0]       imm_10_1;
            logic             imm_11;
            logic [7:0]       imm_19_12;
            logic [reg_w-1:0] rd;
            logic [6:0]       opcode;
        } j;
    } instr_word_t;

endpackage

// ==== hw/station_if.sv ====
`timescale 1ns/1ns

interface station_if;

    // one accepted instruction, valid for a single cycle
    logic                                valid;
    dispatch_pkg::instr_word_t           inst;
    logic [dispatch_pkg::xlen-1:0]       pc;
    logic [dispatch_pkg::reg_w-1:0]      rs1;
    logic [dispatch_pkg::reg_w-1:0]      rs2;
    // source still has a write outstanding at dispatch
    logic                                use_rs1;
    logic                                use_rs2;
    // every slot taken
    logic                                full;

    modport dispatch (
        output valid, inst, pc, rs1, rs2, use_rs1, use_rs2,
        input  full
    );

    modport station (
        input  valid, inst, pc, rs1, rs2, use_rs1, use_rs2,
        output full
    );

endinterface

// ==== hw/dispatch_unit.sv ====
`timescale 1ns/1ns

module dispatch_unit (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  flush,
    input  logic [2*dispatch_pkg::xlen-1:0]       instruction,
    input  logic                                  read_resp,
    input  logic                                  alu_wb_valid,
    input  logic [dispatch_pkg::reg_w-1:0]        alu_wb_rd,
    input  logic                                  mul_wb_valid,
    input  logic [dispatch_pkg::reg_w-1:0]        mul_wb_rd,
    output logic                                  request_new_instr,
    output logic                                  jump_en,
    output logic [dispatch_pkg::xlen-1:0]         jump_pc,
    output logic                                  jalr_en,
    output logic [dispatch_pkg::num_arch_regs-1:0] pending,
    station_if.dispatch                           alu_sif,
    station_if.dispatch                           mul_sif
);

    dispatch_pkg::instr_word_t        iw;
    logic [dispatch_pkg::xlen-1:0]    pc;
    logic [dispatch_pkg::xlen-1:0]    j_imm;
    logic                             accept;
    logic                             is_mul;
    logic                             reads_rs1;
    logic                             reads_rs2;
    logic                             has_rd;
    logic                             writes_rd;
    logic                             wait_rs1;
    logic                             wait_rs2;

    // low half is the word, high half its pc
    assign iw = instruction[dispatch_pkg::xlen-1:0];
    assign pc = instruction[2*dispatch_pkg::xlen-1:dispatch_pkg::xlen];

    // take a word only when both stations have room
    assign request_new_instr = !alu_sif.full && !mul_sif.full && !flush;
    assign accept = read_resp && request_new_instr;

    // mul/div register ops go to the blocking unit
    assign is_mul = (iw.r.opcode == dispatch_pkg::op_reg)
                    && (iw.r.funct7 == dispatch_pkg::funct7_muldiv);

    // operand and destination usage per opcode
    always_comb begin
        reads_rs1 = 1'b0;
        reads_rs2 = 1'b0;
        has_rd = 1'b0;
        case (iw.r.opcode)
            dispatch_pkg::op_lui,
            dispatch_pkg::op_auipc,
            dispatch_pkg::op_jal: begin
                has_rd = 1'b1;
            end
            dispatch_pkg::op_jalr,
            dispatch_pkg::op_load,
            dispatch_pkg::op_imm: begin
                reads_rs1 = 1'b1;
                has_rd = 1'b1;
            end
            dispatch_pkg::op_br,
            dispatch_pkg::op_store: begin
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b1;
            end
            dispatch_pkg::op_reg: begin
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b1;
                has_rd = 1'b1;
            end
            default: begin
                has_rd = 1'b0;
            end
        endcase
    end

    // x0 never goes pending
    assign writes_rd = has_rd && (iw.r.rd != '0);

    // sources already written need no wakeup
    // also keeps an op reading its own rd from waiting on itself
    assign wait_rs1 = reads_rs1 && pending[iw.r.rs1];
    assign wait_rs2 = reads_rs2 && pending[iw.r.rs2];

    // same payload to both, valid picks the station
    assign alu_sif.valid   = accept && !is_mul;
    assign alu_sif.inst    = iw;
    assign alu_sif.pc      = pc;
    assign alu_sif.rs1     = iw.r.rs1;
    assign alu_sif.rs2     = iw.r.rs2;
    assign alu_sif.use_rs1 = wait_rs1;
    assign alu_sif.use_rs2 = wait_rs2;

    assign mul_sif.valid   = accept && is_mul;
    assign mul_sif.inst    = iw;
    assign mul_sif.pc      = pc;
    assign mul_sif.rs1     = iw.r.rs1;
    assign mul_sif.rs2     = iw.r.rs2;
    assign mul_sif.use_rs1 = wait_rs1;
    assign mul_sif.use_rs2 = wait_rs2;

    // sign-extended J immediate, bit 0 always zero
    assign j_imm = {{11{iw.j.imm_20}}, iw.j.imm_20, iw.j.imm_19_12,
                    iw.j.imm_11, iw.j.imm_10_1, 1'b0};

    // redirect fetch in the acceptance cycle
    assign jump_en = accept && (iw.j.opcode == dispatch_pkg::op_jal);
    assign jump_pc = jump_en ? (pc + j_imm) : '0;
    // jalr target needs rs1, only flagged here
    assign jalr_en = accept && (iw.r.opcode == dispatch_pkg::op_jalr);

    // pending write scoreboard
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            pending <= '0;
        end else begin
            // writebacks clear first
            if (alu_wb_valid) begin
                pending[alu_wb_rd] <= 1'b0;
            end
            if (mul_wb_valid) begin
                pending[mul_wb_rd] <= 1'b0;
            end
            // new destination marked busy
            if (accept && writes_rd) begin
                pending[iw.r.rd] <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/issue_station.sv ====
`timescale 1ns/1ns

module issue_station #(
    parameter int STATION_DEPTH = 16,
    parameter int BLOCKING = 0
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   flush,
    input  logic [dispatch_pkg::num_arch_regs-1:0] pending,
    input  logic                                   unit_done,
    station_if.station                             sif,
    output logic                                   issue_valid,
    output dispatch_pkg::instr_word_t              issue_inst,
    output logic [dispatch_pkg::xlen-1:0]          issue_pc
);

    localparam int idx_w = $clog2(STATION_DEPTH);

    // slot payload
    dispatch_pkg::instr_word_t        slot_inst [STATION_DEPTH];
    logic [dispatch_pkg::xlen-1:0]    slot_pc [STATION_DEPTH];
    logic [dispatch_pkg::reg_w-1:0]   slot_rs1 [STATION_DEPTH];
    logic [dispatch_pkg::reg_w-1:0]   slot_rs2 [STATION_DEPTH];
    logic [STATION_DEPTH-1:0]         slot_use_rs1;
    logic [STATION_DEPTH-1:0]         slot_use_rs2;
    // occupancy
    logic [STATION_DEPTH-1:0]         slot_valid;

    logic [STATION_DEPTH-1:0]         ready;
    logic [idx_w-1:0]                 alloc_idx;
    logic [idx_w-1:0]                 sel_idx;
    logic                             sel_found;
    logic                             fire;
    // execution unit occupied, only set when BLOCKING
    logic                             busy;

    assign sif.full = &slot_valid;

    // lowest free slot, scan downward so the lowest wins
    always_comb begin
        alloc_idx = '0;
        for (int i = STATION_DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                alloc_idx = idx_w'(i);
            end
        end
    end

    // wakeup against the scoreboard
    always_comb begin
        for (int i = 0; i < STATION_DEPTH; i++) begin
            ready[i] = slot_valid[i]
                       && (!slot_use_rs1[i] || !pending[slot_rs1[i]])
                       && (!slot_use_rs2[i] || !pending[slot_rs2[i]]);
        end
    end

    // highest ready index, scan upward so the last hit wins
    always_comb begin
        sel_idx = '0;
        sel_found = 1'b0;
        for (int i = 0; i < STATION_DEPTH; i++) begin
            if (ready[i]) begin
                sel_idx = idx_w'(i);
                sel_found = 1'b1;
            end
        end
    end

    // a busy unit holds selection until its writeback
    assign fire = sel_found && !busy;

    // slot payload write on dispatch
    always_ff @(posedge clk) begin
        if (sif.valid) begin
            slot_inst[alloc_idx] <= sif.inst;
            slot_pc[alloc_idx] <= sif.pc;
            slot_rs1[alloc_idx] <= sif.rs1;
            slot_rs2[alloc_idx] <= sif.rs2;
            slot_use_rs1[alloc_idx] <= sif.use_rs1;
            slot_use_rs2[alloc_idx] <= sif.use_rs2;
        end
    end

    // occupancy, alloc and issue never hit the same slot
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            slot_valid <= '0;
        end else begin
            if (fire) begin
                slot_valid[sel_idx] <= 1'b0;
            end
            if (sif.valid) begin
                slot_valid[alloc_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            busy <= 1'b0;
        end else if (fire) begin
            busy <= (BLOCKING != 0);
        end else if (unit_done) begin
            busy <= 1'b0;
        end
    end

    // registered issue port
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            issue_inst <= slot_inst[sel_idx];
            issue_pc <= slot_pc[sel_idx];
        end
    end

endmodule

// ==== hw/dispatch_top.sv ====
`timescale 1ns/1ns

module dispatch_top #(
    parameter int STATION_DEPTH = 16
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              flush,
    input  logic [2*dispatch_pkg::xlen-1:0]   instruction,
    input  logic                              read_resp,
    input  logic                              alu_wb_valid,
    input  logic [dispatch_pkg::reg_w-1:0]    alu_wb_rd,
    input  logic                              mul_wb_valid,
    input  logic [dispatch_pkg::reg_w-1:0]    mul_wb_rd,
    output logic                              request_new_instr,
    output logic                              jump_en,
    output logic [dispatch_pkg::xlen-1:0]     jump_pc,
    output logic                              jalr_en,
    output logic                              issue_valid_alu,
    output logic [31:0]                       issue_inst_alu,
    output logic [dispatch_pkg::xlen-1:0]     issue_pc_alu,
    output logic                              issue_valid_mul,
    output logic [31:0]                       issue_inst_mul,
    output logic [dispatch_pkg::xlen-1:0]     issue_pc_mul
);

    // scoreboard shared by both stations
    logic [dispatch_pkg::num_arch_regs-1:0] pending;

    station_if alu_sif ();
    station_if mul_sif ();

    dispatch_unit unit_i (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .instruction       (instruction),
        .read_resp         (read_resp),
        .alu_wb_valid      (alu_wb_valid),
        .alu_wb_rd         (alu_wb_rd),
        .mul_wb_valid      (mul_wb_valid),
        .mul_wb_rd         (mul_wb_rd),
        .request_new_instr (request_new_instr),
        .jump_en           (jump_en),
        .jump_pc           (jump_pc),
        .jalr_en           (jalr_en),
        .pending           (pending),
        .alu_sif           (alu_sif.dispatch),
        .mul_sif           (mul_sif.dispatch)
    );

    // alu side never blocks
    issue_station #(
        .STATION_DEPTH (STATION_DEPTH),
        .BLOCKING      (0)
    ) alu_station_i (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .pending     (pending),
        .unit_done   (alu_wb_valid),
        .sif         (alu_sif.station),
        .issue_valid (issue_valid_alu),
        .issue_inst  (issue_inst_alu),
        .issue_pc    (issue_pc_alu)
    );

    // multiplier holds one op in flight
    issue_station #(
        .STATION_DEPTH (STATION_DEPTH),
        .BLOCKING      (1)
    ) mul_station_i (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .pending     (pending),
        .unit_done   (mul_wb_valid),
        .sif         (mul_sif.station),
        .issue_valid (issue_valid_mul),
        .issue_inst  (issue_inst_mul),
        .issue_pc    (issue_pc_mul)
    );

endmodule

// ==== bench/dispatch_chk.sv ====
`timescale 1ns/1ns

module dispatch_chk (
    input logic        clk,
    input logic        reset,
    input logic        flush,
    input logic [63:0] instruction,
    input logic        read_resp,
    input logic        request_new_instr,
    input logic        jump_en,
    input logic [31:0] pending
);

    logic       accept;
    logic       writes_rd;
    logic [6:0] opcode;
    logic [4:0] rd;

    assign accept = read_resp && request_new_instr;
    assign opcode = instruction[6:0];
    assign rd = instruction[11:7];
    // lui auipc jal jalr load op-imm op
    assign writes_rd = (rd != 5'd0) && (opcode == 7'b0110111 || opcode == 7'b0010111
                       || opcode == 7'b1101111 || opcode == 7'b1100111
                       || opcode == 7'b0000011 || opcode == 7'b0010011
                       || opcode == 7'b0110011);

    // no renaming, so a second write in flight would lose its wakeup
    no_rewrite_pending: assert property (@(posedge clk) disable iff (reset)
        accept && writes_rd |-> !pending[rd])
        else $error("write to x%0d accepted while still pending", rd);

    // an accepted jal marks its link register busy
    jump_needs_accept: assert property (@(posedge clk) disable iff (reset)
        jump_en |=> ($past(rd) == 5'd0) || pending[$past(rd)])
        else $error("jump_en high without the jal being accepted");

    // flush takes no word and empties the scoreboard
    no_request_in_flush: assert property (@(posedge clk) disable iff (reset)
        flush |=> !$past(request_new_instr) && (pending == '0))
        else $error("request_new_instr high or pending left set by flush");

endmodule

bind dispatch_unit dispatch_chk chk_i (
    .clk               (clk),
    .reset             (reset),
    .flush             (flush),
    .instruction       (instruction),
    .read_resp         (read_resp),
    .request_new_instr (request_new_instr),
    .jump_en           (jump_en),
    .pending           (pending)
);

// ==== bench/dispatch_tb.sv ====
`timescale 1ns/1ns

module dispatch_tb;

    localparam int depth = 16;
    // cycles any single wait may take
    localparam int wait_limit = 200;

    logic        clk;
    logic        reset;
    logic        flush;
    logic [63:0] instruction;
    logic        read_resp;
    logic        alu_wb_valid;
    logic [4:0]  alu_wb_rd;
    logic        mul_wb_valid;
    logic [4:0]  mul_wb_rd;
    logic        request_new_instr;
    logic        jump_en;
    logic [31:0] jump_pc;
    logic        jalr_en;
    logic        issue_valid_alu;
    logic [31:0] issue_inst_alu;
    logic [31:0] issue_pc_alu;
    logic        issue_valid_mul;
    logic [31:0] issue_inst_mul;
    logic [31:0] issue_pc_mul;

    logic [31:0] lfsr_state = 32'h9b55_d2df;
    // jump outputs as seen in the acceptance cycle
    logic        seen_jump;
    logic [31:0] seen_jump_pc;
    logic        seen_jalr;
    // oldest issue not yet consumed by a test
    logic [31:0] got_inst;
    logic [31:0] got_pc;
    // {pc, word} of every issue pulse, per port
    logic [63:0] alu_q[$];
    logic [63:0] mul_q[$];
    int          alu_issues = 0;
    int          mul_issues = 0;

    dispatch_top #(.STATION_DEPTH(depth)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // issue ports are stable at the falling edge
    always @(negedge clk) begin
        if (issue_valid_alu) begin
            alu_issues++;
            alu_q.push_back({issue_pc_alu, issue_inst_alu});
        end
        if (issue_valid_mul) begin
            mul_issues++;
            mul_q.push_back({issue_pc_mul, issue_inst_mul});
        end
    end

    // fibonacci taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // destinations from x1..x15, sources from x16..x31
    function automatic logic [4:0] pick_rd();
        logic [3:0] r;
        r = 4'(lfsr_bits(4));
        return (r == 4'd0) ? 5'd1 : {1'b0, r};
    endfunction

    function automatic logic [4:0] pick_src();
        return {1'b1, 4'(lfsr_bits(4))};
    endfunction

    function automatic logic [31:0] pick_pc();
        return {30'(lfsr_bits(30)), 2'b00};
    endfunction

    // OP major opcode, funct3 zero covers add and mul
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [4:0] rd);
        return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, got);
            stop_run();
        end
    endtask

    // fetch holds the word until the stage takes it
    task automatic dispatch_instr(input logic [31:0] word, input logic [31:0] pc);
        int n;
        n = 0;
        @(posedge clk);
        instruction <= {pc, word};
        read_resp <= 1'b1;
        @(negedge clk);
        while (!request_new_instr) begin
            n++;
            if (n > wait_limit) begin
                $display("Timeout: request_new_instr stayed low with a word waiting");
                stop_run();
            end
            @(negedge clk);
        end
        seen_jump = jump_en;
        seen_jump_pc = jump_pc;
        seen_jalr = jalr_en;
        @(posedge clk);
        read_resp <= 1'b0;
    endtask

    task automatic wait_issue(input logic on_mul);
        int          n;
        logic [63:0] e;
        n = 0;
        while ((on_mul ? mul_q.size() : alu_q.size()) == 0) begin
            n++;
            if (n > wait_limit) begin
                $display("Timeout: nothing issued on the %s port", on_mul ? "mul" : "alu");
                stop_run();
            end
            @(posedge clk);
        end
        if (on_mul) begin
            e = mul_q.pop_front();
        end else begin
            e = alu_q.pop_front();
        end
        got_pc = e[63:32];
        got_inst = e[31:0];
    endtask

    // one-cycle writeback pulse
    task automatic writeback(input logic on_mul, input logic [4:0] rd);
        @(posedge clk);
        if (on_mul) begin
            mul_wb_valid <= 1'b1;
            mul_wb_rd <= rd;
        end else begin
            alu_wb_valid <= 1'b1;
            alu_wb_rd <= rd;
        end
        @(posedge clk);
        mul_wb_valid <= 1'b0;
        alu_wb_valid <= 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    task automatic reset_state();
        @(negedge clk);
        check_value("request_new_instr", 32'(request_new_instr), 32'd1);
        check_value("issue_valid_alu", 32'(issue_valid_alu), 32'd0);
        check_value("issue_valid_mul", 32'(issue_valid_mul), 32'd0);
        check_value("jump_en", 32'(jump_en), 32'd0);
        check_value("jalr_en", 32'(jalr_en), 32'd0);
    endtask

    task automatic alu_issue_and_jal();
        logic [4:0]  rd;
        logic [31:0] word;
        logic [31:0] pc;
        logic [20:0] imm;
        rd = pick_rd();
        word = r_type(7'd0, pick_src(), pick_src(), rd);
        pc = pick_pc();
        dispatch_instr(word, pc);
        check_value("jump_en", 32'(seen_jump), 32'd0);
        wait_issue(1'b0);
        check_value("issue_inst_alu", got_inst, word);
        check_value("issue_pc_alu", got_pc, pc);
        writeback(1'b0, rd);
        // even offset, either sign
        rd = pick_rd();
        imm = {20'(lfsr_bits(20)), 1'b0};
        word = jal_word(imm, rd);
        pc = pick_pc();
        dispatch_instr(word, pc);
        check_value("jump_en", 32'(seen_jump), 32'd1);
        check_value("jump_pc", seen_jump_pc, pc + {{11{imm[20]}}, imm});
        check_value("jalr_en", 32'(seen_jalr), 32'd0);
        wait_issue(1'b0);
        check_value("issue_inst_alu", got_inst, word);
        check_value("issue_pc_alu", got_pc, pc);
        writeback(1'b0, rd);
        // jalr target needs rs1, so only the flag comes back
        rd = pick_rd();
        word = {12'(lfsr_bits(12)), pick_src(), 3'b000, rd, 7'b1100111};
        pc = pick_pc();
        dispatch_instr(word, pc);
        check_value("jalr_en", 32'(seen_jalr), 32'd1);
        check_value("jump_en", 32'(seen_jump), 32'd0);
        wait_issue(1'b0);
        check_value("issue_inst_alu", got_inst, word);
        check_value("issue_pc_alu", got_pc, pc);
        writeback(1'b0, rd);
    endtask

    task automatic mul_routing();
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [31:0] word_a;
        logic [31:0] word_b;
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        int          alu_before;
        int          mul_before;
        ra = pick_rd();
        rb = 5'((ra % 15) + 1);
        word_a = r_type(7'd1, pick_src(), pick_src(), ra);
        word_b = r_type(7'd1, pick_src(), pick_src(), rb);
        pc_a = pick_pc();
        pc_b = pick_pc();
        alu_before = alu_issues;
        mul_before = mul_issues;
        dispatch_instr(word_a, pc_a);
        dispatch_instr(word_b, pc_b);
        wait_issue(1'b1);
        check_value("issue_inst_mul", got_inst, word_a);
        check_value("issue_pc_mul", got_pc, pc_a);
        // second op held while the unit is busy
        idle(20);
        check_value("mul issue count", mul_issues, mul_before + 1);
        writeback(1'b1, ra);
        wait_issue(1'b1);
        check_value("issue_inst_mul", got_inst, word_b);
        check_value("issue_pc_mul", got_pc, pc_b);
        writeback(1'b1, rb);
        idle(2);
        check_value("alu issue count", alu_issues, alu_before);
    endtask

    task automatic wakeup_after_writeback();
        logic [4:0]  rd;
        logic [31:0] mul_word;
        logic [31:0] add_word;
        int          alu_before;
        rd = pick_rd();
        rd = (rd == 5'd5) ? 5'd6 : rd;
        mul_word = r_type(7'd1, pick_src(), pick_src(), 5'd5);
        add_word = r_type(7'd0, pick_src(), 5'd5, rd);
        alu_before = alu_issues;
        dispatch_instr(mul_word, pick_pc());
        dispatch_instr(add_word, pick_pc());
        wait_issue(1'b1);
        check_value("issue_inst_mul", got_inst, mul_word);
        idle(20);
        check_value("alu issue count", alu_issues, alu_before);
        writeback(1'b1, 5'd5);
        wait_issue(1'b0);
        check_value("issue_inst_alu", got_inst, add_word);
        writeback(1'b0, rd);
    endtask

    task automatic full_stall_release();
        logic [31:0]      base;
        logic [depth-1:0] seen;
        int               k;
        int               alu_before;
        base = pick_pc();
        seen = '0;
        dispatch_instr(r_type(7'd1, pick_src(), pick_src(), 5'd5), pick_pc());
        wait_issue(1'b1);
        alu_before = alu_issues;
        // all wait on x5, destinations x6 upward
        for (int i = 0; i < depth; i++) begin
            dispatch_instr(r_type(7'd0, 5'd0, 5'd5, 5'(6 + i)), base + 32'(4 * i));
        end
        @(negedge clk);
        check_value("request_new_instr", 32'(request_new_instr), 32'd0);
        writeback(1'b1, 5'd5);
        for (int i = 0; i < depth; i++) begin
            wait_issue(1'b0);
            k = int'((got_pc - base) >> 2);
            assert (k >= 0 && k < depth && !seen[k]) else begin
                $display("Fail at %0t ns: issue_pc_alu %h repeated or unknown", $time, got_pc);
                stop_run();
            end
            seen[k] = 1'b1;
            check_value("issue_inst_alu", got_inst, r_type(7'd0, 5'd0, 5'd5, 5'(6 + k)));
        end
        idle(3);
        check_value("alu issue count", alu_issues, alu_before + depth);
        @(negedge clk);
        check_value("request_new_instr", 32'(request_new_instr), 32'd1);
        for (int i = 0; i < depth; i++) begin
            writeback(1'b0, 5'(6 + i));
        end
    endtask

    task automatic flush_clears_all();
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [31:0] word;
        int          alu_before;
        int          mul_before;
        ra = pick_rd();
        rb = 5'((ra % 15) + 1);
        dispatch_instr(r_type(7'd1, pick_src(), pick_src(), ra), pick_pc());
        wait_issue(1'b1);
        // one waiter in each station
        dispatch_instr(r_type(7'd0, pick_src(), ra, rb), pick_pc());
        dispatch_instr(r_type(7'd1, ra, pick_src(), 5'((rb % 15) + 1)), pick_pc());
        alu_before = alu_issues;
        mul_before = mul_issues;
        @(posedge clk);
        flush <= 1'b1;
        @(negedge clk);
        check_value("request_new_instr", 32'(request_new_instr), 32'd0);
        @(posedge clk);
        flush <= 1'b0;
        idle(20);
        check_value("alu issue count", alu_issues, alu_before);
        check_value("mul issue count", mul_issues, mul_before);
        // ra no longer pending, no writeback needed
        word = r_type(7'd0, pick_src(), ra, rb);
        dispatch_instr(word, pick_pc());
        wait_issue(1'b0);
        check_value("issue_inst_alu", got_inst, word);
        writeback(1'b0, rb);
    endtask

    initial begin
        reset <= 1'b1;
        flush <= 1'b0;
        instruction <= '0;
        read_resp <= 1'b0;
        alu_wb_valid <= 1'b0;
        alu_wb_rd <= '0;
        mul_wb_valid <= 1'b0;
        mul_wb_rd <= '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        reset_state();
        alu_issue_and_jal();
        mul_routing();
        wakeup_after_writeback();
        full_stall_release();
        flush_clears_all();
        idle(2);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== src.f ====
hw/dispatch_pkg.sv
hw/station_if.sv
hw/dispatch_unit.sv
hw/issue_station.sv
hw/dispatch_top.sv
bench/dispatch_chk.sv
bench/dispatch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the dispatch testbench, exit status reports pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module dispatch_tb -o dispatch_sim &&
./obj_dir/dispatch_sim || exit 1
